// File: Bender.yml
package:
  name: ntm_write

sources:
  - logic/ntm_size_pkg.sv
  - logic/ntm_fix_pkg.sv
  - logic/ntm_elem_if.sv
  - logic/ntm_vector_buffer.sv
  - logic/ntm_writing.sv
  - logic/ntm_vector_fix_multiplier.sv
  - logic/ntm_vector_fix_adder.sv
  - logic/ntm_memory_bank.sv
  - logic/ntm_write_top.sv
  - target: simulation
    files:
      - testbench/ntm_write_sva.sv
      - testbench/ntm_write_tb.sv

// File: logic/ntm_elem_if.sv
/*
 * One matrix element in flight between pipeline stages
 * Row and column index, memory operand and product/result word
 */

`timescale 1ns/1ps

interface ntm_elem_if;
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  // Element present this cycle
  logic                        valid;
  // Position in the matrix
  logic [J_BITS-1:0]           j;
  logic [K_BITS-1:0]           k;
  // Memory operand M(j;k)
  logic signed [DATA_BITS-1:0] data_m;
  // Product w(j)·a(k), or the sum once added
  logic signed [DATA_BITS-1:0] data_p;

  // Producing stage
  modport src (output valid, j, k, data_m, data_p);
  // Consuming stage
  modport dst (input valid, j, k, data_m, data_p);

endinterface

// File: logic/ntm_fix_pkg.sv
/*
 * Q8.8 fixed-point format for the NTM write block
 * Element width, product width and saturation bounds
 * Round-to-nearest constant for the product shift
 */

package ntm_fix_pkg;

  ////////////////////////////////////////
  // Number format
  ////////////////////////////////////////

  // Signed element, 8 integer and 8 fractional bits
  localparam int DATA_BITS = 16;
  localparam int FRAC_BITS = 8;

  // Full product of two elements
  localparam int PROD_BITS = 2 * DATA_BITS;

  ////////////////////////////////////////
  // Saturation and rounding
  ////////////////////////////////////////

  // Bounds of a 16-bit signed word
  localparam logic signed [DATA_BITS-1:0] FIX_MAX = 16'sh7FFF;
  localparam logic signed [DATA_BITS-1:0] FIX_MIN = -16'sh8000;

  // Half an LSB of the result, at product scale
  localparam logic signed [PROD_BITS-1:0] ROUND_HALF = 32'sd1 <<< (FRAC_BITS - 1);

endpackage

// File: logic/ntm_memory_bank.sv
/*
 * N×W memory matrix in registers
 * Host preload and read-back ports, pipeline read and write ports
 * Both read ports return data one cycle after the address
 */

`timescale 1ns/1ps

module ntm_memory_bank (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    busy,
  input  logic                                    m_load_enable,
  input  logic [ntm_size_pkg::J_BITS-1:0]         m_load_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         m_load_k,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] m_load_data,
  input  logic [ntm_size_pkg::J_BITS-1:0]         m_read_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         m_read_k,
  output logic signed [ntm_fix_pkg::DATA_BITS-1:0] m_read_data,
  input  logic [ntm_size_pkg::J_BITS-1:0]         rd_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         rd_k,
  output logic signed [ntm_fix_pkg::DATA_BITS-1:0] rd_data,
  ntm_elem_if.dst                                 wr
);
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  logic signed [DATA_BITS-1:0] mem [SIZE_N][SIZE_W];

  ////////////////////////////////////////
  // Write and read ports
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int r = 0; r < SIZE_N; r++) begin
        for (int c = 0; c < SIZE_W; c++) begin
          mem[r][c] <= '0;
        end
      end
      m_read_data <= '0;
      rd_data     <= '0;
    end else begin
      // Pipeline write-back
      if (wr.valid) begin
        mem[wr.j][wr.k] <= wr.data_p;
      end else if (m_load_enable && !busy) begin
        // Host preload only between passes
        mem[m_load_j][m_load_k] <= m_load_data;
      end
      // Registered reads
      m_read_data <= mem[m_read_j][m_read_k];
      rd_data     <= mem[rd_j][rd_k];
    end
  end

endmodule

// File: logic/ntm_size_pkg.sv
/*
 * NTM write block geometry
 * Memory matrix is SIZE_N rows by SIZE_W columns
 * Index widths for the row and column counters
 */

package ntm_size_pkg;

  ////////////////////////////////////////
  // Matrix geometry
  ////////////////////////////////////////

  // Rows, one weight per row
  localparam int SIZE_N = 4;
  // Columns, one add value per column
  localparam int SIZE_W = 8;

  // Index widths
  localparam int J_BITS = $clog2(SIZE_N);
  localparam int K_BITS = $clog2(SIZE_W);

endpackage

// File: logic/ntm_vector_buffer.sv
/*
 * Weighting and add vector buffer
 * Streams fill w and a in order from index 0
 * Combinational read by index for the multiplier
 */

`timescale 1ns/1ps

module ntm_vector_buffer (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    busy,
  input  logic                                    start_accept,
  input  logic                                    w_in_enable,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] w_in,
  input  logic                                    a_in_enable,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] a_in,
  input  logic [ntm_size_pkg::J_BITS-1:0]         w_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         a_k,
  output logic signed [ntm_fix_pkg::DATA_BITS-1:0] w_out,
  output logic signed [ntm_fix_pkg::DATA_BITS-1:0] a_out
);
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  // Vector storage
  logic signed [DATA_BITS-1:0] w_mem [SIZE_N];
  logic signed [DATA_BITS-1:0] a_mem [SIZE_W];

  // Next load position of each stream
  logic [J_BITS-1:0] w_ptr;
  logic [K_BITS-1:0] a_ptr;

  ////////////////////////////////////////
  // Loading
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_ptr <= '0;
      a_ptr <= '0;
      for (int n = 0; n < SIZE_N; n++) begin
        w_mem[n] <= '0;
      end
      for (int n = 0; n < SIZE_W; n++) begin
        a_mem[n] <= '0;
      end
    end else begin
      // Loads refused during a pass
      if (w_in_enable && !busy) begin
        w_mem[w_ptr] <= w_in;
        w_ptr        <= w_ptr + 1'b1;
      end
      if (a_in_enable && !busy) begin
        a_mem[a_ptr] <= a_in;
        a_ptr        <= a_ptr + 1'b1;
      end
      // New pass, next load restarts at index 0
      if (start_accept) begin
        w_ptr <= '0;
        a_ptr <= '0;
      end
    end
  end

  // Lookup for the current element
  assign w_out = w_mem[w_j];
  assign a_out = a_mem[a_k];

endmodule

// File: logic/ntm_vector_fix_adder.sv
/*
 * Saturating Q8.8 add of memory operand and product
 * One register stage, result goes to the memory write port
 */

`timescale 1ns/1ps

module ntm_vector_fix_adder (
  input  logic    CLK,
  input  logic    RST,
  ntm_elem_if.dst prod,
  ntm_elem_if.src result
);
  import ntm_fix_pkg::*;

  // One guard bit catches overflow
  logic signed [DATA_BITS:0]   sum;
  logic signed [DATA_BITS-1:0] sat;

  assign sum = prod.data_m + prod.data_p;

  always_comb begin
    if (sum > FIX_MAX) begin
      sat = FIX_MAX;
    end else if (sum < FIX_MIN) begin
      sat = FIX_MIN;
    end else begin
      sat = sum[DATA_BITS-1:0];
    end
  end

  ////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= prod.valid;
    end
  end

  // Old word kept alongside the new one
  always_ff @(posedge CLK) begin
    result.j      <= prod.j;
    result.k      <= prod.k;
    result.data_m <= prod.data_m;
    result.data_p <= sat;
  end

endmodule

// File: logic/ntm_vector_fix_multiplier.sv
/*
 * Q8.8 product w(j)·a(k), two pipeline stages
 * Stage 1 full signed product, stage 2 round to nearest and saturate
 */

`timescale 1ns/1ps

module ntm_vector_fix_multiplier (
  input  logic                                    CLK,
  input  logic                                    RST,
  output logic [ntm_size_pkg::J_BITS-1:0]         w_j,
  output logic [ntm_size_pkg::K_BITS-1:0]         a_k,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] w_val,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] a_val,
  ntm_elem_if.dst                                 issue,
  ntm_elem_if.src                                 prod
);
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  // Stage 1 registers
  logic                        s1_valid;
  logic [J_BITS-1:0]           s1_j;
  logic [K_BITS-1:0]           s1_k;
  logic signed [DATA_BITS-1:0] s1_m;
  logic signed [PROD_BITS-1:0] s1_prod;

  // Rounding path
  logic signed [PROD_BITS-1:0]           rounded;
  logic signed [PROD_BITS-FRAC_BITS-1:0] shifted;
  logic signed [DATA_BITS-1:0]           sat;

  // Buffer lookup by the issued element's indices
  assign w_j = issue.j;
  assign a_k = issue.k;

  ////////////////////////////////////////
  // Stage 1, multiply
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue.valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_j    <= issue.j;
    s1_k    <= issue.k;
    s1_m    <= issue.data_m;
    s1_prod <= w_val * a_val;
  end

  ////////////////////////////////////////
  // Stage 2, round and clamp
  ////////////////////////////////////////

  // Add half an LSB then floor, ties go up
  assign rounded = s1_prod + ROUND_HALF;
  assign shifted = rounded[PROD_BITS-1:FRAC_BITS];

  always_comb begin
    if (shifted > FIX_MAX) begin
      sat = FIX_MAX;
    end else if (shifted < FIX_MIN) begin
      sat = FIX_MIN;
    end else begin
      sat = shifted[DATA_BITS-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod.valid <= 1'b0;
    end else begin
      prod.valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    prod.j      <= s1_j;
    prod.k      <= s1_k;
    prod.data_m <= s1_m;
    prod.data_p <= sat;
  end

endmodule

// File: logic/ntm_write_top.sv
/*
 * NTM memory write block, M(j;k) = M(j;k) + w(j)·a(k)
 * Vector buffer, controller, Q8.8 multiply and add, memory bank
 */

`timescale 1ns/1ps

module ntm_write_top (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    start,
  output logic                                    ready,
  input  logic                                    w_in_enable,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] w_in,
  input  logic                                    a_in_enable,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] a_in,
  input  logic                                    m_load_enable,
  input  logic [ntm_size_pkg::J_BITS-1:0]         m_load_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         m_load_k,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] m_load_data,
  input  logic [ntm_size_pkg::J_BITS-1:0]         m_read_j,
  input  logic [ntm_size_pkg::K_BITS-1:0]         m_read_k,
  output logic signed [ntm_fix_pkg::DATA_BITS-1:0] m_read_data
);
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  // Pass control
  logic busy;
  logic start_accept;

  // Pipeline memory read
  logic [J_BITS-1:0]           rd_j;
  logic [K_BITS-1:0]           rd_k;
  logic signed [DATA_BITS-1:0] rd_data;

  // Vector lookup
  logic [J_BITS-1:0]           w_j;
  logic [K_BITS-1:0]           a_k;
  logic signed [DATA_BITS-1:0] w_val;
  logic signed [DATA_BITS-1:0] a_val;

  // Issue, product and write-back stages
  ntm_elem_if issue_if ();
  ntm_elem_if prod_if ();
  ntm_elem_if write_if ();

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  ntm_vector_buffer buffer_inst (
    .CLK          (CLK),
    .RST          (RST),
    .busy         (busy),
    .start_accept (start_accept),
    .w_in_enable  (w_in_enable),
    .w_in         (w_in),
    .a_in_enable  (a_in_enable),
    .a_in         (a_in),
    .w_j          (w_j),
    .a_k          (a_k),
    .w_out        (w_val),
    .a_out        (a_val)
  );

  ntm_writing writing_inst (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .ready        (ready),
    .busy         (busy),
    .start_accept (start_accept),
    .rd_j         (rd_j),
    .rd_k         (rd_k),
    .rd_data      (rd_data),
    .issue        (issue_if.src)
  );

  ntm_vector_fix_multiplier multiplier_inst (
    .CLK   (CLK),
    .RST   (RST),
    .w_j   (w_j),
    .a_k   (a_k),
    .w_val (w_val),
    .a_val (a_val),
    .issue (issue_if.dst),
    .prod  (prod_if.src)
  );

  ntm_vector_fix_adder adder_inst (
    .CLK    (CLK),
    .RST    (RST),
    .prod   (prod_if.dst),
    .result (write_if.src)
  );

  ntm_memory_bank memory_inst (
    .CLK           (CLK),
    .RST           (RST),
    .busy          (busy),
    .m_load_enable (m_load_enable),
    .m_load_j      (m_load_j),
    .m_load_k      (m_load_k),
    .m_load_data   (m_load_data),
    .m_read_j      (m_read_j),
    .m_read_k      (m_read_k),
    .m_read_data   (m_read_data),
    .rd_j          (rd_j),
    .rd_k          (rd_k),
    .rd_data       (rd_data),
    .wr            (write_if.dst)
  );

endmodule

// File: logic/ntm_writing.sv
/*
 * Write pass controller
 * Idle, issue and drain FSM walking j outer and k inner
 * Issues one memory read per cycle, pulses ready after the last write
 */

`timescale 1ns/1ps

module ntm_writing (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    start,
  output logic                                    ready,
  output logic                                    busy,
  output logic                                    start_accept,
  output logic [ntm_size_pkg::J_BITS-1:0]         rd_j,
  output logic [ntm_size_pkg::K_BITS-1:0]         rd_k,
  input  logic signed [ntm_fix_pkg::DATA_BITS-1:0] rd_data,
  ntm_elem_if.src                                 issue
);
  import ntm_size_pkg::*;

  // FSM encoding
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

  // Read, two multiply stages, add, write
  localparam logic [1:0] DRAIN_LAST = 2'd3;

  logic [1:0]        state;
  logic [J_BITS-1:0] j_cnt;
  logic [K_BITS-1:0] k_cnt;
  logic [1:0]        drain_cnt;
  logic              last_elem;

  assign busy         = (state != ST_IDLE);
  assign start_accept = start && (state == ST_IDLE);
  assign last_elem    = (j_cnt == J_BITS'(SIZE_N - 1)) && (k_cnt == K_BITS'(SIZE_W - 1));

  // Memory read address straight from the counters
  assign rd_j = j_cnt;
  assign rd_k = k_cnt;

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      j_cnt     <= '0;
      k_cnt     <= '0;
      drain_cnt <= '0;
      ready     <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ISSUE;
            j_cnt <= '0;
            k_cnt <= '0;
          end
        end
        ST_ISSUE: begin
          // k inner, j outer
          k_cnt <= k_cnt + 1'b1;
          if (k_cnt == K_BITS'(SIZE_W - 1)) begin
            j_cnt <= j_cnt + 1'b1;
          end
          if (last_elem) begin
            state     <= ST_DRAIN;
            drain_cnt <= '0;
          end
        end
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          // Last element written on this edge
          if (drain_cnt == DRAIN_LAST) begin
            state <= ST_IDLE;
            ready <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Issue stage
  ////////////////////////////////////////

  // Indices delayed to line up with the registered memory operand
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      issue.valid <= 1'b0;
      issue.j     <= '0;
      issue.k     <= '0;
    end else begin
      issue.valid <= (state == ST_ISSUE);
      issue.j     <= j_cnt;
      issue.k     <= k_cnt;
    end
  end

  assign issue.data_m = rd_data;
  // No product yet at this stage
  assign issue.data_p = '0;

endmodule

// File: project.f
logic/ntm_size_pkg.sv
logic/ntm_fix_pkg.sv
logic/ntm_elem_if.sv
logic/ntm_vector_buffer.sv
logic/ntm_writing.sv
logic/ntm_vector_fix_multiplier.sv
logic/ntm_vector_fix_adder.sv
logic/ntm_memory_bank.sv
logic/ntm_write_top.sv
testbench/ntm_write_sva.sv
testbench/ntm_write_tb.sv

// File: testbench/ntm_write_cases.txt
# case <name> <passes> <busy poke 0/1> <fill hex or lfsr>
# vec <w0..w3> <a0..a7> as Q8.8 hex, probe <j> <k> <expected hex>
case exact 1 0 0100
vec 0100 0200 ff00 0080 0100 0080 fe00 0040 0300 ff80 0010 0000
probe 0 0 0200
probe 0 2 ff00
probe 1 4 0700
probe 2 1 0080
probe 2 5 0180
probe 3 3 0120
probe 3 6 0108
probe 1 7 0100
case rounding 1 0 0000
vec 0001 0003 fffd 0055 0080 007f ff80 ff7f 0180 0181 017f 0100
probe 0 0 0001
probe 0 1 0000
probe 0 2 0000
probe 0 3 ffff
probe 0 5 0002
probe 0 6 0001
probe 1 0 0002
probe 1 1 0001
probe 2 0 ffff
probe 2 2 0002
probe 3 1 002a
case sat_high 1 0 4000
vec 7fff 8000 0100 c000 7fff 0100 4000 c000 8000 0000 3000 d000
probe 0 0 7fff
probe 0 4 c000
probe 1 4 7fff
probe 2 2 7fff
probe 2 3 0000
probe 3 2 c000
case sat_low 1 0 c000
vec 7fff 8000 0100 c000 7fff 0100 4000 c000 8000 0000 3000 d000
probe 0 0 3fff
probe 0 4 8000
probe 2 3 8000
probe 2 6 f000
probe 2 7 9000
probe 3 2 8000
case accumulate 2 0 lfsr
vec 0080 ff40 0120 0010 0100 0033 ffc0 0200 0007 fe80 0155 8000
case busy 1 1 0200
vec 0040 0100 ff00 0200 0400 0100 0200 0080 fc00 0000 0040 0180
probe 0 0 0300
probe 0 7 0260
probe 1 0 0600
probe 2 4 0600
probe 2 6 01c0
probe 3 4 fa00
probe 3 7 0500

// File: testbench/ntm_write_sva.sv
/*
 * Write pass controller assertions
 * Ready pulse shape, pass bracketing, idle issue stage and
 * counter progress under a start while busy
 */

`timescale 1ns/1ps

module ntm_write_sva (
  input logic                            CLK,
  input logic                            RST,
  input logic                            start,
  input logic                            ready,
  input logic                            busy,
  input logic                            start_accept,
  input logic                            issue_valid,
  input logic [1:0]                      state,
  input logic [ntm_size_pkg::J_BITS-1:0] j_cnt,
  input logic [ntm_size_pkg::K_BITS-1:0] k_cnt,
  input logic                            last_elem
);

  // Issue state code of the controller FSM
  localparam logic [1:0] ST_ISSUE = 2'd1;

  // High from an accepted start until its ready
  logic pass_armed;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pass_armed <= 1'b0;
    end else if (start_accept) begin
      pass_armed <= 1'b1;
    end else if (ready) begin
      pass_armed <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready held high for more than one cycle");

  ready_needs_start: assert property (@(posedge CLK) disable iff (RST) ready |-> pass_armed)
    else $error("ready rose without an accepted start");

  idle_no_issue: assert property (@(posedge CLK) disable iff (RST) !busy |-> !issue_valid)
    else $error("issue valid while the controller is idle");

  // Restart attempt mid pass leaves the counters walking
  busy_start_ignored: assert property (@(posedge CLK) disable iff (RST)
      (state == ST_ISSUE && start && !last_elem)
      |=> ({j_cnt, k_cnt} == $past({j_cnt, k_cnt}) + 1'b1))
    else $error("start during a pass disturbed the j and k counters");

endmodule

// File: testbench/ntm_write_tb.sv
/*
 * Testbench for the NTM memory write block
 * Reads cases from a file, loads vectors and memory, runs passes
 * Checks probes and the whole matrix against a Q8.8 model
 */

`timescale 1ns/1ps

module ntm_write_tb;
  import ntm_size_pkg::*;
  import ntm_fix_pkg::*;

  // Cycles allowed from start to ready
  localparam int READY_LIMIT = 100;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  logic                        ready;
  logic                        w_in_enable;
  logic                        a_in_enable;
  logic                        m_load_enable;
  logic signed [DATA_BITS-1:0] w_in;
  logic signed [DATA_BITS-1:0] a_in;
  logic signed [DATA_BITS-1:0] m_load_data;
  logic signed [DATA_BITS-1:0] m_read_data;
  logic [J_BITS-1:0]           m_load_j;
  logic [J_BITS-1:0]           m_read_j;
  logic [K_BITS-1:0]           m_load_k;
  logic [K_BITS-1:0]           m_read_k;

  // Case file parsing
  logic [8*256-1:0] line;
  logic [8*16-1:0]  kw;
  logic [8*16-1:0]  case_name;
  logic [8*16-1:0]  fill_tok;
  integer           fd;
  integer           n;
  integer           passes;
  integer           poke;
  integer           pj;
  integer           pk;
  logic             fill_lfsr;
  logic [15:0]      fill_value;
  logic [15:0]      probe_exp;
  logic [15:0]      got;

  // Vectors and expected memory contents
  logic signed [DATA_BITS-1:0] w_vec [SIZE_N];
  logic signed [DATA_BITS-1:0] a_vec [SIZE_W];
  logic signed [DATA_BITS-1:0] model_mem [SIZE_N][SIZE_W];
  logic [15:0]                 lfsr_state;

  ntm_write_top ntm_write_top_inst (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .ready         (ready),
    .w_in_enable   (w_in_enable),
    .w_in          (w_in),
    .a_in_enable   (a_in_enable),
    .a_in          (a_in),
    .m_load_enable (m_load_enable),
    .m_load_j      (m_load_j),
    .m_load_k      (m_load_k),
    .m_load_data   (m_load_data),
    .m_read_j      (m_read_j),
    .m_read_k      (m_read_k),
    .m_read_data   (m_read_data)
  );

  bind ntm_writing ntm_write_sva sva_inst (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .ready        (ready),
    .busy         (busy),
    .start_accept (start_accept),
    .issue_valid  (issue.valid),
    .state        (state),
    .j_cnt        (j_cnt),
    .k_cnt        (k_cnt),
    .last_elem    (last_elem)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Q8.8 reference model
  ////////////////////////////////////////

  function automatic logic signed [DATA_BITS-1:0] saturate_word(input integer v);
    if (v > FIX_MAX) saturate_word = FIX_MAX;
    else if (v < FIX_MIN) saturate_word = FIX_MIN;
    else saturate_word = v[DATA_BITS-1:0];
  endfunction

  // Round to nearest, ties upward, then clamp
  function automatic logic signed [DATA_BITS-1:0] q_product(
    input logic signed [DATA_BITS-1:0] w, input logic signed [DATA_BITS-1:0] a);
    integer p;
    p = w * a;
    p = (p + (1 << (FRAC_BITS - 1))) >>> FRAC_BITS;
    q_product = saturate_word(p);
  endfunction

  function automatic logic signed [DATA_BITS-1:0] q_sum(
    input logic signed [DATA_BITS-1:0] m, input logic signed [DATA_BITS-1:0] p);
    integer s;
    s = m + p;
    q_sum = saturate_word(s);
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit drawn
  task automatic draw_word(output logic [15:0] word);
    word = '0;
    for (int b = 0; b < 16; b++) begin
      word       = {word[14:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic update_model();
    for (int j = 0; j < SIZE_N; j++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        model_mem[j][k] = q_sum(model_mem[j][k], q_product(w_vec[j], a_vec[k]));
      end
    end
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input logic [8*16-1:0] name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %0s expected %h actual %h", name, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // Bus activity, all from a falling edge
  ////////////////////////////////////////

  // Registered read port, data valid at the next falling edge
  task automatic read_word(input int j, input int k, output logic [15:0] data);
    m_read_j = j[J_BITS-1:0];
    m_read_k = k[K_BITS-1:0];
    @(negedge CLK);
    data = m_read_data;
  endtask

  task automatic load_vectors();
    for (int i = 0; i < SIZE_W; i++) begin
      w_in_enable = (i < SIZE_N);
      if (i < SIZE_N) w_in = w_vec[i];
      a_in_enable = 1'b1;
      a_in        = a_vec[i];
      @(negedge CLK);
    end
    w_in_enable = 1'b0;
    a_in_enable = 1'b0;
  endtask

  task automatic fill_memory(input logic use_lfsr, input logic [15:0] value);
    logic [15:0] word;
    for (int j = 0; j < SIZE_N; j++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        if (use_lfsr) draw_word(word);
        else word = value;
        m_load_enable   = 1'b1;
        m_load_j        = j[J_BITS-1:0];
        m_load_k        = k[K_BITS-1:0];
        m_load_data     = word;
        model_mem[j][k] = word;
        @(negedge CLK);
      end
    end
    m_load_enable = 1'b0;
  endtask

  // Restart, last-word load and vector writes, all to be ignored
  task automatic drive_busy_poke(input logic on);
    start         = on;
    m_load_enable = on;
    m_load_j      = '1;
    m_load_k      = '1;
    m_load_data   = 16'sh1234;
    w_in_enable   = on;
    w_in          = 16'sh7fff;
    a_in_enable   = on;
    a_in          = 16'sh7fff;
  endtask

  task automatic run_pass(input logic with_poke);
    int timer;
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    timer = 0;
    while (ready !== 1'b1 && timer < READY_LIMIT) begin
      if (with_poke) drive_busy_poke(timer == 2);
      @(negedge CLK);
      timer++;
    end
    if (ready !== 1'b1) abort_run("ready never came after start");
    @(negedge CLK);
  endtask

  task automatic check_matrix(input logic [8*16-1:0] name);
    logic [15:0] data;
    for (int j = 0; j < SIZE_N; j++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        read_word(j, k, data);
        check_value(name, model_mem[j][k], data);
      end
    end
  endtask

  ////////////////////////////////////////
  // Case file lines
  ////////////////////////////////////////

  task automatic process_line();
    if (kw == "case") begin
      case_name = '0;
      fill_tok  = '0;
      n = $sscanf(line, "%s %s %d %d %s", kw, case_name, passes, poke, fill_tok);
      if (n != 5) abort_run("malformed case line in the case file");
      fill_lfsr = (fill_tok == "lfsr");
      if (!fill_lfsr) n = $sscanf(fill_tok, "%h", fill_value);
    end else if (kw == "vec") begin
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", kw,
                  w_vec[0], w_vec[1], w_vec[2], w_vec[3], a_vec[0], a_vec[1],
                  a_vec[2], a_vec[3], a_vec[4], a_vec[5], a_vec[6], a_vec[7]);
      if (n != 13) abort_run("malformed vec line in the case file");
      load_vectors();
      fill_memory(fill_lfsr, fill_value);
      for (int p = 0; p < passes; p++) begin
        run_pass(poke != 0);
        update_model();
      end
      check_matrix(case_name);
    end else if (kw == "probe") begin
      n = $sscanf(line, "%s %d %d %h", kw, pj, pk, probe_exp);
      if (n != 4) abort_run("malformed probe line in the case file");
      read_word(pj, pk, got);
      check_value(case_name, probe_exp, got);
    end else begin
      abort_run("unknown keyword in the case file");
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    RST           = 1'b1;
    start         = 1'b0;
    w_in_enable   = 1'b0;
    a_in_enable   = 1'b0;
    m_load_enable = 1'b0;
    w_in          = '0;
    a_in          = '0;
    m_load_j      = '0;
    m_load_k      = '0;
    m_load_data   = '0;
    m_read_j      = '0;
    m_read_k      = '0;
    fill_lfsr     = 1'b0;
    fill_value    = '0;
    case_name     = '0;
    lfsr_state    = 16'd37;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Cleared memory, no ready without a start
    for (int j = 0; j < SIZE_N; j++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        read_word(j, k, got);
        check_value("reset", 16'h0000, got);
        check_value("reset_ready", 16'h0000, {15'b0, ready});
      end
    end

    fd = $fopen("testbench/ntm_write_cases.txt", "r");
    if (fd == 0) abort_run("cannot open the case file");
    while (!$feof(fd)) begin
      line = '0;
      kw   = '0;
      if ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", kw);
        if (n == 1 && kw != "#") process_line();
      end
    end
    $fclose(fd);

    $display("RESULT: PASS");
    $finish;
  end

endmodule
